//--- Makefile
# Verilator build and run of the prefetch testbench

sim:
	verilator --binary --timing -f tb.f --top-module tb_fetch -o tb_fetch
	@out="$$(./obj_dir/tb_fetch)"; echo "$$out"; \
	echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- axil_fetch_top.sv
////////////////////////////////////////////////////////////
// AXI-lite instruction prefetch, top level
// Request, response, FIFO and unpacker stages
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fetch_consts.svh"

module axil_fetch_top
(
	input  logic                     S_AXI_ACLK,
	input  logic                     fifo_reset,
	// CPU side
	input  logic                     i_new_pc,
	input  logic [`FETCH_ADDR_W-1:0] i_pc,
	input  logic                     i_clear_cache,
	input  logic                     i_ready,
	output logic [`FETCH_INSN_W-1:0] o_insn,
	output logic [`FETCH_ADDR_W-1:0] o_pc,
	output logic                     o_valid,
	output logic                     o_illegal,
	// AXI-lite read master
	output logic                     o_arvalid,
	input  logic                     i_arready,
	output logic [`FETCH_ADDR_W-1:0] o_araddr,
	output logic [2:0]               o_arprot,
	input  logic                     i_rvalid,
	output logic                     o_rready,
	input  logic [`FETCH_BUS_W-1:0]  i_rdata,
	input  logic [1:0]               i_rresp
);

	logic                 full_bus;
	logic                 flush_pending;
	logic                 word_wr;
	fetch_pkg::bus_word_t word_data;
	logic                 word_err;
	fetch_pkg::bus_word_t fifo_data;
	logic                 fifo_err;
	logic                 fifo_empty;
	logic                 fifo_rd;
	logic                 word_taken;
	logic                 hold_extra;

	// Fixed access type, responses always taken
	assign o_arprot = `FETCH_ARPROT;
	assign o_rready = 1'b1;

	fetch_request u_request (
		.S_AXI_ACLK      (S_AXI_ACLK),     .fifo_reset   (fifo_reset),
		.i_new_pc        (i_new_pc),       .i_pc         (i_pc),
		.i_clear_cache   (i_clear_cache),  .i_arready    (i_arready),
		.i_full_bus      (full_bus),       .i_flush_pending (flush_pending),
		.i_word_taken    (word_taken),     .i_hold_extra (hold_extra),
		.o_arvalid       (o_arvalid),      .o_araddr     (o_araddr)
	);

	fetch_response u_response (
		.S_AXI_ACLK      (S_AXI_ACLK),     .fifo_reset   (fifo_reset),
		.i_new_pc        (i_new_pc),       .i_clear_cache (i_clear_cache),
		.i_arvalid       (o_arvalid),      .i_arready    (i_arready),
		.i_rvalid        (i_rvalid),       .i_rdata      (i_rdata),
		.i_rresp         (i_rresp),        .o_full_bus   (full_bus),
		.o_flush_pending (flush_pending),  .o_word_wr    (word_wr),
		.o_word_data     (word_data),      .o_word_err   (word_err)
	);

	// Word buffer between bus and CPU
	fetch_fifo u_fifo (
		.S_AXI_ACLK      (S_AXI_ACLK),     .fifo_reset   (fifo_reset),
		.i_new_pc        (i_new_pc),       .i_clear_cache (i_clear_cache),
		.i_wr            (word_wr),        .i_data       (word_data),
		.i_err           (word_err),       .i_rd         (fifo_rd),
		.o_data          (fifo_data),      .o_err        (fifo_err),
		.o_empty         (fifo_empty)
	);

	insn_unpacker u_unpacker (
		.S_AXI_ACLK      (S_AXI_ACLK),     .fifo_reset   (fifo_reset),
		.i_new_pc        (i_new_pc),       .i_pc         (i_pc),
		.i_clear_cache   (i_clear_cache),  .i_ready      (i_ready),
		.i_fifo_data     (fifo_data),      .i_fifo_err   (fifo_err),
		.i_fifo_empty    (fifo_empty),     .o_fifo_rd    (fifo_rd),
		.o_word_taken    (word_taken),     .o_hold_extra (hold_extra),
		.o_insn          (o_insn),         .o_pc         (o_pc),
		.o_valid         (o_valid),        .o_illegal    (o_illegal)
	);

endmodule

//--- fetch_consts.svh
////////////////////////////////////////////////////////////
// Prefetch constants
// Address, bus and instruction widths
// Outstanding limits and the fixed read protection code
////////////////////////////////////////////////////////////
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// Bus and instruction widths
`define FETCH_ADDR_W	32
`define FETCH_BUS_W	64
`define FETCH_INSN_W	32
// Byte offset bits inside one bus word
`define FETCH_WORD_LSB	3

// Most words requested but not yet taken, also the FIFO depth
`define FETCH_LIMIT	16
// Outstanding counter width
`define FETCH_LGDEPTH	8

// Unprivileged, secure, instruction access
`define FETCH_ARPROT	3'b100

`endif

//--- fetch_fifo.sv
////////////////////////////////////////////////////////////
// Synchronous FIFO of fetched bus words
// Each entry carries its bus error bit
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_fifo
(
	input  logic                 S_AXI_ACLK,
	input  logic                 fifo_reset,
	input  logic                 i_new_pc,
	input  logic                 i_clear_cache,
	input  logic                 i_wr,
	input  fetch_pkg::bus_word_t i_data,
	input  logic                 i_err,
	input  logic                 i_rd,
	output fetch_pkg::bus_word_t o_data,
	output logic                 o_err,
	output logic                 o_empty
);

	localparam int LGFIFO = $clog2(`FETCH_LIMIT);

	fetch_pkg::bus_word_t mem [`FETCH_LIMIT];
	logic                 err_mem [`FETCH_LIMIT];
	logic [LGFIFO:0]      wr_ptr;
	logic [LGFIFO:0]      rd_ptr;
	logic                 flush;
	logic                 full;
	logic                 wr_en;
	logic                 rd_en;

	assign flush = fifo_reset || i_new_pc || i_clear_cache;

	// Extra pointer bit tells full from empty
	assign o_empty = (wr_ptr == rd_ptr);
	assign full    = (wr_ptr[LGFIFO] != rd_ptr[LGFIFO])
		&& (wr_ptr[LGFIFO-1:0] == rd_ptr[LGFIFO-1:0]);

	assign rd_en = i_rd && !o_empty;
	// Full FIFO still takes a word when the head leaves
	assign wr_en = i_wr && (!full || rd_en);

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1;
		end
	end

	// Storage
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (wr_en)
		begin
			mem[wr_ptr[LGFIFO-1:0]]     <= i_data;
			err_mem[wr_ptr[LGFIFO-1:0]] <= i_err;
		end
	end

	// Head of queue, visible without a read
	assign o_data = mem[rd_ptr[LGFIFO-1:0]];
	assign o_err  = err_mem[rd_ptr[LGFIFO-1:0]];

endmodule

//--- fetch_pkg.sv
////////////////////////////////////////////////////////////
// Shared prefetch types
// Bus word union, whole word or instruction slots
////////////////////////////////////////////////////////////
`include "fetch_consts.svh"

package fetch_pkg;

	// One returned bus word
	// Response and FIFO see the whole word
	// Unpacker picks one instruction slot out of it
	typedef union packed
	{
		logic [`FETCH_BUS_W-1:0] word;
		logic [`FETCH_BUS_W/`FETCH_INSN_W-1:0][`FETCH_INSN_W-1:0] slot;
	} bus_word_t;

endpackage

//--- fetch_request.sv
////////////////////////////////////////////////////////////
// Read address stage of the prefetch
// Address walk, redirect capture and request throttle
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_request
(
	input  logic                     S_AXI_ACLK,
	input  logic                     fifo_reset,
	input  logic                     i_new_pc,
	input  logic [`FETCH_ADDR_W-1:0] i_pc,
	input  logic                     i_clear_cache,
	input  logic                     i_arready,
	input  logic                     i_full_bus,
	input  logic                     i_flush_pending,
	input  logic                     i_word_taken,
	input  logic                     i_hold_extra,
	output logic                     o_arvalid,
	output logic [`FETCH_ADDR_W-1:0] o_araddr
);

	logic                      flush;
	logic                      ar_free;
	logic                      halted;
	logic                      pending_new_pc;
	logic [`FETCH_ADDR_W-1:0]  pending_pc;
	logic [`FETCH_LGDEPTH-1:0] fill;
	logic [`FETCH_LGDEPTH-1:0] demand;

	assign flush = fifo_reset || i_new_pc || i_clear_cache;
	// Address channel can take a new beat
	assign ar_free = !o_arvalid || i_arready;

	////////////////////////////////////////////////////////////
	// Fill count
	////////////////////////////////////////////////////////////

	// Words asked for but not yet taken by the unpacker
	// Stale requests accepted after a redirect do not count
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (flush)
			fill <= '0;
		else
		begin
			case ({ o_arvalid && i_arready && !i_flush_pending, i_word_taken })
			2'b10: fill <= fill + 1;
			2'b01: fill <= fill - 1;
			default: fill <= fill;
			endcase
		end
	end

	// Requested, in the channel, or parked in the output register
	assign demand = fill + `FETCH_LGDEPTH'(o_arvalid) + `FETCH_LGDEPTH'(i_hold_extra);

	// Idle from reset or a cache clear until the next redirect
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset || i_clear_cache)
			halted <= 1'b1;
		else if (i_new_pc)
			halted <= 1'b0;
	end

	////////////////////////////////////////////////////////////
	// Address valid and address walk
	////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
			o_arvalid <= 1'b0;
		else if (ar_free)
		begin
			o_arvalid <= 1'b1;
			// Throttle at the word limit
			if (demand >= `FETCH_LGDEPTH'(`FETCH_LIMIT))
				o_arvalid <= 1'b0;
			if (i_clear_cache || i_full_bus)
				o_arvalid <= 1'b0;
			if (halted && !i_new_pc)
				o_arvalid <= 1'b0;
		end
	end

	// Redirect seen while a request was stalled
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset || i_clear_cache)
			pending_new_pc <= 1'b0;
		else if (ar_free)
			pending_new_pc <= 1'b0;
		else if (i_new_pc)
			pending_new_pc <= 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_new_pc)
			pending_pc <= i_pc;
	end

	// Next address, aligned to a bus word after the first
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (ar_free)
		begin
			if (i_new_pc)
				o_araddr <= i_pc;
			else if (pending_new_pc)
				o_araddr <= pending_pc;
			else if (o_arvalid)
				o_araddr <= { o_araddr[`FETCH_ADDR_W-1:`FETCH_WORD_LSB],
					{`FETCH_WORD_LSB{1'b0}} } + `FETCH_ADDR_W'(1 << `FETCH_WORD_LSB);
		end
	end

endmodule

//--- fetch_response.sv
////////////////////////////////////////////////////////////
// Read response stage of the prefetch
// Outstanding count, stale response discard, byte swap
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_response
(
	input  logic                    S_AXI_ACLK,
	input  logic                    fifo_reset,
	input  logic                    i_new_pc,
	input  logic                    i_clear_cache,
	input  logic                    i_arvalid,
	input  logic                    i_arready,
	input  logic                    i_rvalid,
	input  logic [`FETCH_BUS_W-1:0] i_rdata,
	input  logic [1:0]              i_rresp,
	output logic                    o_full_bus,
	output logic                    o_flush_pending,
	output logic                    o_word_wr,
	output fetch_pkg::bus_word_t    o_word_data,
	output logic                    o_word_err
);

	logic                      redirect;
	logic                      flushing;
	logic [`FETCH_LGDEPTH-1:0] outstanding;
	logic [`FETCH_LGDEPTH-1:0] next_outstanding;
	logic [`FETCH_LGDEPTH-1:0] flushcount;
	logic [`FETCH_LGDEPTH-1:0] new_flushcount;

	assign redirect = i_new_pc || i_clear_cache;

	// Requests accepted minus responses seen
	always_comb
	begin
		next_outstanding = outstanding;
		case ({ i_arvalid && i_arready, i_rvalid })
		2'b10: next_outstanding = outstanding + 1;
		2'b01: next_outstanding = outstanding - 1;
		default: next_outstanding = outstanding;
		endcase
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
		begin
			outstanding <= '0;
			o_full_bus  <= 1'b0;
		end
		else
		begin
			outstanding <= next_outstanding;
			o_full_bus  <= (next_outstanding >= {`FETCH_LGDEPTH{1'b1}});
		end
	end

	// In flight at a redirect, including a request still waiting
	assign new_flushcount = outstanding + `FETCH_LGDEPTH'(i_arvalid)
		- `FETCH_LGDEPTH'(i_rvalid);

	////////////////////////////////////////////////////////////
	// Flush tracking
	////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
		begin
			flushcount      <= '0;
			flushing        <= 1'b0;
			o_flush_pending <= 1'b0;
		end
		else if (redirect)
		begin
			flushcount      <= new_flushcount;
			flushing        <= (new_flushcount != '0);
			// Stalled request, its acceptance is stale
			o_flush_pending <= i_arvalid && !i_arready;
		end
		else
		begin
			if (i_rvalid && flushcount != '0)
			begin
				flushcount <= flushcount - 1;
				flushing   <= (flushcount > 1);
			end
			if (i_arready)
				o_flush_pending <= 1'b0;
		end
	end

	// Keep only responses from the current stream
	assign o_word_wr  = i_rvalid && !flushing;
	assign o_word_err = i_rresp[1];

	// Byte reverse each 32-bit lane
	always_comb
	begin
		for (int lane = 0; lane < `FETCH_BUS_W/32; lane++)
			for (int b = 0; b < 4; b++)
				o_word_data.word[lane*32 + (3-b)*8 +: 8] = i_rdata[lane*32 + b*8 +: 8];
	end

endmodule

//--- insn_unpacker.sv
////////////////////////////////////////////////////////////
// Output stage of the prefetch
// Word to instruction split, PC tracking, illegal flag
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fetch_consts.svh"

module insn_unpacker
(
	input  logic                      S_AXI_ACLK,
	input  logic                      fifo_reset,
	input  logic                      i_new_pc,
	input  logic [`FETCH_ADDR_W-1:0]  i_pc,
	input  logic                      i_clear_cache,
	input  logic                      i_ready,
	input  fetch_pkg::bus_word_t      i_fifo_data,
	input  logic                      i_fifo_err,
	input  logic                      i_fifo_empty,
	output logic                      o_fifo_rd,
	output logic                      o_word_taken,
	output logic                      o_hold_extra,
	output logic [`FETCH_INSN_W-1:0]  o_insn,
	output logic [`FETCH_ADDR_W-1:0]  o_pc,
	output logic                      o_valid,
	output logic                      o_illegal
);

	fetch_pkg::bus_word_t out_word;
	logic [1:0]           out_fill;
	logic                 flush;
	logic                 shift;

	assign flush = fifo_reset || i_new_pc || i_clear_cache;

	// Skip the low slot only on the first word after a redirect
	assign shift = o_valid ? 1'b0 : o_pc[`FETCH_WORD_LSB-1];

	// Pull a word once the last slot is going
	assign o_fifo_rd    = !o_valid || (i_ready && (out_fill <= 2'd1));
	assign o_word_taken = o_fifo_rd && !i_fifo_empty;
	// Word stays parked past this cycle
	assign o_hold_extra = o_valid && (!i_ready || (out_fill > 2'd1));

	////////////////////////////////////////////////////////////
	// Output register control
	////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (flush)
			o_valid <= 1'b0;
		else if (!o_valid || i_ready)
			o_valid <= o_word_taken || (out_fill > {1'b0, o_valid});
	end

	// Slots still to present from the held word
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (flush)
			out_fill <= '0;
		else if (o_fifo_rd)
			out_fill <= i_fifo_empty ? 2'd0 : (2'd2 - {1'b0, shift});
		else if (i_ready && out_fill != '0)
			out_fill <= out_fill - 1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_fifo_rd)
			out_word <= i_fifo_data;
	end

	// PC low word bit picks the slot on show
	assign o_insn = out_word.slot[o_pc[`FETCH_WORD_LSB-1]];

	// PC stops on a bad fetch
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
			o_pc <= '0;
		else if (i_new_pc)
			o_pc <= i_pc;
		else if (o_valid && i_ready && !o_illegal)
			o_pc <= { o_pc[`FETCH_ADDR_W-1:2], 2'b00 } + `FETCH_ADDR_W'(4);
	end

	// Sticky bus error
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (flush)
			o_illegal <= 1'b0;
		else if (!o_illegal && o_word_taken)
			o_illegal <= i_fifo_err;
	end

endmodule

//--- tb.f
+incdir+.
fetch_pkg.sv
fetch_request.sv
fetch_response.sv
fetch_fifo.sv
insn_unpacker.sv
axil_fetch_top.sv
tb_fetch.sv

//--- tb_fetch_tasks.svh
////////////////////////////////////////////////////////////
// Prefetch testbench helpers
// Memory data, expected instructions, value check
// Directed tests, each entered 1 ns after a clock edge
////////////////////////////////////////////////////////////
`ifndef TB_FETCH_TASKS_SVH
`define TB_FETCH_TASKS_SVH

// Raw bus word, each lane holds its own byte address
function automatic fetch_pkg::bus_word_t bus_data(input logic [`FETCH_ADDR_W-1:0] addr);
	fetch_pkg::bus_word_t     w;
	logic [`FETCH_ADDR_W-1:0] base;
	base      = {addr[`FETCH_ADDR_W-1:3], 3'b000};
	w.slot[0] = base ^ 32'ha500_0000;
	w.slot[1] = (base + 32'd4) ^ 32'ha500_0000;
	return w;
endfunction

// Instruction at a PC is its lane value byte reversed
function automatic logic [`FETCH_INSN_W-1:0] insn_at(input logic [`FETCH_ADDR_W-1:0] pc);
	fetch_pkg::bus_word_t     w;
	logic [`FETCH_INSN_W-1:0] lane;
	w    = bus_data(pc);
	lane = w.slot[pc[2]];
	return {lane[7:0], lane[15:8], lane[23:16], lane[31:24]};
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
	checks = checks + 1;
	if (got !== exp)
	begin
		errors = errors + 1;
		$display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
	end
endtask

// Single cycle redirect
task automatic new_pc_pulse(input logic [`FETCH_ADDR_W-1:0] pc);
	i_new_pc = 1'b1;
	i_pc     = pc;
	@(posedge S_AXI_ACLK);
	#1;
	i_new_pc = 1'b0;
endtask

// Take count instructions from start_pc on, in order
task automatic accept_stream(input logic [`FETCH_ADDR_W-1:0] start_pc, input int count);
	logic [`FETCH_ADDR_W-1:0] pc;
	int                       got;
	int                       idle;
	pc      = start_pc;
	got     = 0;
	idle    = 0;
	i_ready = 1'b1;
	while (got < count && idle < 100)
	begin
		@(posedge S_AXI_ACLK);
		idle = idle + 1;
		if (o_valid)
		begin
			check_value("o_pc", o_pc, pc);
			check_value("o_insn", o_insn, insn_at(pc));
			check_value("o_illegal", 32'(o_illegal), 32'd0);
			pc   = pc + 32'd4;
			got  = got + 1;
			idle = 0;
		end
	end
	#1;
	i_ready = 1'b0;
	if (got < count)
	begin
		errors = errors + 1;
		$display("Timed out waiting for the instruction at pc %h", pc);
	end
endtask

task automatic reset_state_low();
	@(posedge S_AXI_ACLK);
	check_value("o_arvalid", 32'(o_arvalid), 32'd0);
	check_value("o_valid", 32'(o_valid), 32'd0);
	check_value("o_illegal", 32'(o_illegal), 32'd0);
	#1;
endtask

task automatic stream_aligned_pc();
	new_pc_pulse(32'h0000_1000);
	accept_stream(32'h0000_1000, 40);
endtask

// Upper slot of the first word comes out first
task automatic stream_offset_pc();
	new_pc_pulse(32'h0000_2004);
	accept_stream(32'h0000_2004, 12);
endtask

// Old stream still in flight when the new PC lands
task automatic redirect_mid_stream();
	new_pc_pulse(32'h0000_3000);
	accept_stream(32'h0000_3000, 5);
	new_pc_pulse(32'h0000_4408);
	accept_stream(32'h0000_4408, 16);
endtask

// Reads stop near the word limit while the CPU stalls
task automatic throttle_with_ready_low();
	int start;
	int taken;
	new_pc_pulse(32'h0000_5000);
	start = ar_count;
	repeat (60)
	begin
		@(posedge S_AXI_ACLK);
		// Output must hold while stalled
		if (o_valid)
		begin
			check_value("o_pc", o_pc, 32'h0000_5000);
			check_value("o_insn", o_insn, insn_at(32'h0000_5000));
		end
		#1;
		taken = ar_count - start;
		if (taken > `FETCH_LIMIT + 1)
		begin
			errors = errors + 1;
			$display("Too many reads issued with i_ready low, %0d addresses taken", taken);
		end
	end
	accept_stream(32'h0000_5000, 40);
endtask

task automatic bus_error_to_illegal();
	int idle;
	new_pc_pulse(32'h0000_7ff8);
	accept_stream(32'h0000_7ff8, 2);
	idle = 0;
	do
	begin
		@(posedge S_AXI_ACLK);
		idle = idle + 1;
	end
	while (!o_valid && idle < 100);
	check_value("o_valid", 32'(o_valid), 32'd1);
	check_value("o_illegal", 32'(o_illegal), 32'd1);
	check_value("o_pc", o_pc, 32'h0000_8000);
	#1;
	// Accepting more must not move the PC
	i_ready = 1'b1;
	repeat (20)
	begin
		@(posedge S_AXI_ACLK);
		check_value("o_pc", o_pc, 32'h0000_8000);
		check_value("o_illegal", 32'(o_illegal), 32'd1);
	end
	#1;
	i_ready = 1'b0;
	new_pc_pulse(32'h0000_0200);
	@(posedge S_AXI_ACLK);
	check_value("o_illegal", 32'(o_illegal), 32'd0);
	#1;
	accept_stream(32'h0000_0200, 6);
endtask

task automatic clear_cache_idles();
	int idle;
	new_pc_pulse(32'h0000_6000);
	accept_stream(32'h0000_6000, 4);
	i_clear_cache = 1'b1;
	i_ready       = 1'b1;
	@(posedge S_AXI_ACLK);
	#1;
	i_clear_cache = 1'b0;
	// A stalled read may still finish its handshake
	idle = 0;
	do
	begin
		@(posedge S_AXI_ACLK);
		check_value("o_valid", 32'(o_valid), 32'd0);
		idle = idle + 1;
	end
	while (o_arvalid && idle < 5);
	check_value("o_arvalid", 32'(o_arvalid), 32'd0);
	repeat (40)
	begin
		@(posedge S_AXI_ACLK);
		check_value("o_valid", 32'(o_valid), 32'd0);
		check_value("o_arvalid", 32'(o_arvalid), 32'd0);
	end
	#1;
	i_ready = 1'b0;
	new_pc_pulse(32'h0000_6100);
	accept_stream(32'h0000_6100, 6);
endtask

`endif

//--- tb_fetch.sv
////////////////////////////////////////////////////////////
// Prefetch testbench top
// Clock, reset, AXI-lite read memory model, watchdog
// Directed test sequence and final report
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fetch_consts.svh"

module tb_fetch;

	// About 500 clocks of tests, four times over, at 10 ns each
	localparam int TEST_CLOCKS = 500;
	localparam int WATCHDOG_NS = 4 * TEST_CLOCKS * 10;

	logic                     S_AXI_ACLK;
	logic                     fifo_reset;
	logic                     i_new_pc;
	logic [`FETCH_ADDR_W-1:0] i_pc;
	logic                     i_clear_cache;
	logic                     i_ready;
	logic [`FETCH_INSN_W-1:0] o_insn;
	logic [`FETCH_ADDR_W-1:0] o_pc;
	logic                     o_valid;
	logic                     o_illegal;
	logic                     o_arvalid;
	logic                     i_arready;
	logic [`FETCH_ADDR_W-1:0] o_araddr;
	logic [2:0]               o_arprot;
	logic                     i_rvalid;
	logic                     o_rready;
	logic [`FETCH_BUS_W-1:0]  i_rdata;
	logic [1:0]               i_rresp;

	// Memory model state
	integer                   seed;
	int                       cycle;
	int                       ar_wait;
	int                       ar_count;
	logic [`FETCH_ADDR_W-1:0] rsp_addr [$];
	int                       rsp_due [$];
	fetch_pkg::bus_word_t     beat;
	// Scoreboard totals
	int                       checks;
	int                       errors;

	`include "tb_fetch_tasks.svh"

	axil_fetch_top u_dut (
		.S_AXI_ACLK (S_AXI_ACLK),   .fifo_reset    (fifo_reset),
		.i_new_pc   (i_new_pc),     .i_pc          (i_pc),
		.i_clear_cache (i_clear_cache), .i_ready   (i_ready),
		.o_insn     (o_insn),       .o_pc          (o_pc),
		.o_valid    (o_valid),      .o_illegal     (o_illegal),
		.o_arvalid  (o_arvalid),    .i_arready     (i_arready),
		.o_araddr   (o_araddr),     .o_arprot      (o_arprot),
		.i_rvalid   (i_rvalid),     .o_rready      (o_rready),
		.i_rdata    (i_rdata),      .i_rresp       (i_rresp)
	);

	// 10 ns clock
	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever
			#5 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	////////////////////////////////////////////////////////////
	// AXI-lite read memory
	////////////////////////////////////////////////////////////

	initial
	begin
		seed      = 32'hc7ba;
		cycle     = 0;
		ar_wait   = -1;
		ar_count  = 0;
		i_arready = 1'b0;
		i_rvalid  = 1'b0;
		i_rdata   = '0;
		i_rresp   = 2'b00;
		forever
		begin
			@(posedge S_AXI_ACLK);
			cycle = cycle + 1;
			// Every beat on offer must be taken
			if (i_rvalid)
				check_value("o_rready", 32'(o_rready), 32'd1);
			if (fifo_reset)
			begin
				rsp_addr.delete();
				rsp_due.delete();
			end
			else if (o_arvalid && i_arready)
			begin
				// Address taken, data due 1 to 3 cycles on
				ar_count = ar_count + 1;
				// Instruction, secure, unprivileged
				check_value("o_arprot", 32'(o_arprot), 32'h0000_0004);
				rsp_addr.push_back(o_araddr);
				rsp_due.push_back(cycle + int'($unsigned($random(seed)) % 32'd3));
			end
			#1;
			// Accept after 0 to 2 idle cycles
			i_arready = 1'b0;
			if (o_arvalid && !fifo_reset)
			begin
				if (ar_wait < 0)
					ar_wait = int'($unsigned($random(seed)) % 32'd3);
				if (ar_wait == 0)
					i_arready = 1'b1;
				ar_wait = ar_wait - 1;
			end
			// In order, oldest beat only
			i_rvalid = 1'b0;
			if (rsp_due.size() > 0 && rsp_due[0] <= cycle)
			begin
				beat     = bus_data(rsp_addr[0]);
				i_rvalid = 1'b1;
				i_rdata  = beat.word;
				// Error region from 0x8000 up
				i_rresp  = (rsp_addr[0] >= 32'h0000_8000) ? 2'b10 : 2'b00;
				void'(rsp_addr.pop_front());
				void'(rsp_due.pop_front());
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		checks        = 0;
		errors        = 0;
		fifo_reset    = 1'b1;
		i_new_pc      = 1'b0;
		i_pc          = '0;
		i_clear_cache = 1'b0;
		i_ready       = 1'b0;
		// Reset held for 3 clocks
		repeat (3) @(posedge S_AXI_ACLK);
		#1;
		fifo_reset = 1'b0;
		reset_state_low();
		stream_aligned_pc();
		stream_offset_pc();
		redirect_mid_stream();
		throttle_with_ready_low();
		bus_error_to_illegal();
		clear_cache_idles();
		$display("Checks run %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// Hang guard
	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
		$display("Checks run %0d, errors %0d", checks, errors);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule
